// File: common/apb_pkg.sv
package apb_pkg;

    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // register map
    typedef enum logic [7:0] {
        REG_CTRL     = 8'h00,
        REG_PRESCALE = 8'h04,
        REG_TIME     = 8'h08,
        REG_STATUS   = 8'h0C
    } reg_addr_e;

    // REG_CTRL fields
    localparam int CTRL_RUN_BIT = 0;
    localparam int CTRL_ADJ_BIT = 1;
    // 1 selects seconds
    localparam int CTRL_SEL_BIT = 2;

    // REG_STATUS fields
    localparam int STATUS_PAUSED_BIT = 0;

endpackage

// File: common/stopwatch_config.svh
`ifndef STOPWATCH_CONFIG_SVH
`define STOPWATCH_CONFIG_SVH

//////////////////////////////
// debounce and prescale
//////////////////////////////

// cycles a press must stay high
`define SW_DEB_LEN 16

// prescale register width, wide enough for one second at 50 MHz
`define SW_PRESCALE_W 26

// one second at 50 MHz
`define SW_PRESCALE_RESET 50000000

//////////////////////////////
// display timing
//////////////////////////////

// cycles per digit-scan step
`define SW_REFRESH_DIV 16

// cycles per blink half period
`define SW_BLINK_DIV 64

`endif

// File: common/stopwatch_pkg.sv
`include "stopwatch_config.svh"

package stopwatch_pkg;

    // one bcd digit
    typedef logic [3:0] digit_t;

    // min10, min1, sec10, sec1 from msb down
    typedef logic [15:0] bcd_time_t;

    // active low, dp on bit 7
    typedef logic [7:0] seg_t;

    // one-cold anode select, bit 3 is min10
    typedef logic [3:0] anode_t;

    // count tick period in clk cycles
    typedef logic [`SW_PRESCALE_W-1:0] prescale_t;

    // scan order follows the encoding
    typedef enum logic [1:0] {
        DIG_MIN10 = 2'd0,
        DIG_MIN1  = 2'd1,
        DIG_SEC10 = 2'd2,
        DIG_SEC1  = 2'd3
    } scan_digit_e;

endpackage

// File: hw/apb_regs.sv
`timescale 1ns/1ns
`include "stopwatch_config.svh"

module apb_regs
    import stopwatch_pkg::*;
    import apb_pkg::*;
(
    input  logic      clk,
    input  logic      rst_deb,
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  apb_addr_t paddr,
    input  apb_data_t pwdata,
    input  bcd_time_t cur_time,
    input  logic      paused,
    output apb_data_t prdata,
    output logic      pready,
    output logic      pslverr,
    output logic      run,
    output logic      adj,
    output logic      sel,
    output prescale_t prescale,
    output logic      load_pulse,
    output bcd_time_t load_time
);

    logic access;
    logic mapped;
    logic time_ok;
    logic wr_ok;

    // tens digits up to 5, ones digits up to 9
    function automatic logic bcd_valid(input bcd_time_t t);
        return (t[15:12] <= 4'd5) && (t[11:8] <= 4'd9)
            && (t[7:4] <= 4'd5) && (t[3:0] <= 4'd9);
    endfunction

    //////////////////////////////
    // decode
    //////////////////////////////

    // access phase of a transfer, no wait states
    assign access  = psel && penable;
    assign pready  = 1'b1;
    assign time_ok = bcd_valid(pwdata[15:0]);

    always_comb
    begin
        mapped = 1'b1;
        prdata = '0;
        case (paddr)
            REG_CTRL:
            begin
                prdata[CTRL_RUN_BIT] = run;
                prdata[CTRL_ADJ_BIT] = adj;
                prdata[CTRL_SEL_BIT] = sel;
            end
            REG_PRESCALE: prdata = apb_data_t'(prescale);
            REG_TIME:     prdata = apb_data_t'(cur_time);
            REG_STATUS:   prdata[STATUS_PAUSED_BIT] = paused;
            default:      mapped = 1'b0;
        endcase
    end

    // status is read only, time must be bcd
    assign pslverr = access && (!mapped
                   || (pwrite && paddr == REG_STATUS)
                   || (pwrite && paddr == REG_TIME && !time_ok));

    assign wr_ok = access && pwrite && !pslverr;

    // counter takes the load at the end of the access cycle
    assign load_pulse = wr_ok && (paddr == REG_TIME);
    assign load_time  = pwdata[15:0];

    //////////////////////////////
    // registers
    //////////////////////////////

    always_ff @(posedge clk or posedge rst_deb)
    begin
        if (rst_deb)
        begin
            run      <= 1'b0;
            adj      <= 1'b0;
            sel      <= 1'b0;
            prescale <= prescale_t'(`SW_PRESCALE_RESET);
        end
        else if (wr_ok)
        begin
            if (paddr == REG_CTRL)
            begin
                run <= pwdata[CTRL_RUN_BIT];
                adj <= pwdata[CTRL_ADJ_BIT];
                sel <= pwdata[CTRL_SEL_BIT];
            end
            if (paddr == REG_PRESCALE)
                prescale <= pwdata[`SW_PRESCALE_W-1:0];
        end
    end

endmodule

// File: hw/button_debouncer.sv
`timescale 1ns/1ns
`include "stopwatch_config.svh"

module button_debouncer (
    input  logic clk,
    input  logic rst_deb,
    input  logic btn,
    output logic pause_pulse
);

    localparam int DEB_LEN = `SW_DEB_LEN;

    // one bit per sampled cycle of btn
    logic [DEB_LEN-1:0] hist;
    logic [DEB_LEN-1:0] hist_next;
    // set once the press has been reported
    logic               fired;

    // any low sample empties the history
    assign hist_next = btn ? {hist[DEB_LEN-2:0], 1'b1} : '0;

    always_ff @(posedge clk or posedge rst_deb)
    begin
        if (rst_deb)
        begin
            hist        <= '0;
            fired       <= 1'b0;
            pause_pulse <= 1'b0;
        end
        else
        begin
            hist        <= hist_next;
            // single pulse on the cycle the history fills
            pause_pulse <= (&hist_next) && !fired;
            if (!btn)
                fired <= 1'b0;
            else if (&hist_next)
                fired <= 1'b1;
        end
    end

endmodule

// File: hw/display_scan.sv
`timescale 1ns/1ns

module display_scan
    import stopwatch_pkg::*;
(
    input  logic      clk,
    input  logic      rst_deb,
    input  bcd_time_t cur_time,
    input  logic      refresh_en,
    input  logic      blink,
    input  logic      adj,
    input  logic      sel,
    output seg_t      seg,
    output anode_t    an
);

    scan_digit_e state;
    scan_digit_e state_next;
    // display stays dark until the first refresh step
    logic        lit;
    logic        lit_next;
    digit_t      digit;
    logic        in_sel_field;
    logic        blank;

    // active low segments, dp kept off
    function automatic seg_t seg_decode(input digit_t d);
        case (d)
            4'd0:    return 8'b1100_0000;
            4'd1:    return 8'b1111_1001;
            4'd2:    return 8'b1010_0100;
            4'd3:    return 8'b1011_0000;
            4'd4:    return 8'b1001_1001;
            4'd5:    return 8'b1001_0010;
            4'd6:    return 8'b1000_0010;
            4'd7:    return 8'b1111_1000;
            4'd8:    return 8'b1000_0000;
            4'd9:    return 8'b1001_0000;
            default: return 8'b1111_1111;
        endcase
    endfunction

    //////////////////////////////
    // scan state
    //////////////////////////////

    // min10 -> min1 -> sec10 -> sec1, two bit wrap
    assign state_next = refresh_en ? scan_digit_e'(state + 2'd1) : state;
    assign lit_next   = lit || refresh_en;

    always_comb
    begin
        case (state_next)
            DIG_MIN10: digit = cur_time[15:12];
            DIG_MIN1:  digit = cur_time[11:8];
            DIG_SEC10: digit = cur_time[7:4];
            default:   digit = cur_time[3:0];
        endcase
    end

    // sel high picks the seconds pair
    assign in_sel_field = sel ? (state_next == DIG_SEC10 || state_next == DIG_SEC1)
                              : (state_next == DIG_MIN10 || state_next == DIG_MIN1);
    assign blank        = adj && !blink && in_sel_field;

    always_ff @(posedge clk or posedge rst_deb)
    begin
        if (rst_deb)
        begin
            // first step lands on min10
            state <= DIG_SEC1;
            lit   <= 1'b0;
            seg   <= '1;
            an    <= '1;
        end
        else
        begin
            state <= state_next;
            lit   <= lit_next;
            if (lit_next)
            begin
                // min10 on bit 3 down to sec1 on bit 0
                an  <= ~(anode_t'(4'b1000) >> state_next);
                seg <= blank ? seg_t'('1) : seg_decode(digit);
            end
        end
    end

endmodule

// File: hw/stopwatch_top.sv
`timescale 1ns/1ns

module stopwatch_top
    import stopwatch_pkg::*;
    import apb_pkg::*;
(
    input  logic      clk,
    input  logic      rst_deb,
    input  logic      pause_btn,
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  apb_addr_t paddr,
    input  apb_data_t pwdata,
    output apb_data_t prdata,
    output logic      pready,
    output logic      pslverr,
    output seg_t      seg,
    output anode_t    an
);

    // stage links
    logic      pause_pulse;
    logic      run;
    logic      adj;
    logic      sel;
    prescale_t prescale;
    logic      load_pulse;
    bcd_time_t load_time;
    bcd_time_t cur_time;
    logic      paused;
    logic      count_tick;
    logic      adj_tick;
    logic      refresh_en;
    logic      blink;

    //////////////////////////////
    // pipeline stages
    //////////////////////////////

    button_debouncer u_button_debouncer (
        .clk         (clk),
        .rst_deb     (rst_deb),
        .btn         (pause_btn),
        .pause_pulse (pause_pulse)
    );

    // software control and readback
    apb_regs u_apb_regs (
        .clk        (clk),
        .rst_deb    (rst_deb),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .cur_time   (cur_time),
        .paused     (paused),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .run        (run),
        .adj        (adj),
        .sel        (sel),
        .prescale   (prescale),
        .load_pulse (load_pulse),
        .load_time  (load_time)
    );

    timebase u_timebase (
        .clk        (clk),
        .rst_deb    (rst_deb),
        .run        (run),
        .adj        (adj),
        .prescale   (prescale),
        .count_tick (count_tick),
        .adj_tick   (adj_tick),
        .refresh_en (refresh_en),
        .blink      (blink)
    );

    time_counter u_time_counter (
        .clk         (clk),
        .rst_deb     (rst_deb),
        .count_tick  (count_tick),
        .adj_tick    (adj_tick),
        .pause_pulse (pause_pulse),
        .adj         (adj),
        .sel         (sel),
        .load_pulse  (load_pulse),
        .load_time   (load_time),
        .cur_time    (cur_time),
        .paused      (paused)
    );

    // multiplexed common-anode output
    display_scan u_display_scan (
        .clk        (clk),
        .rst_deb    (rst_deb),
        .cur_time   (cur_time),
        .refresh_en (refresh_en),
        .blink      (blink),
        .adj        (adj),
        .sel        (sel),
        .seg        (seg),
        .an         (an)
    );

endmodule

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module stopwatch_tb \
    || { echo "verilator build failed"; exit 1; }
out=$(./obj_dir/Vstopwatch_tb)
echo "$out"
echo "$out" | grep -q "PASS: all tests" && exit 0 || { echo "simulation failed"; exit 1; }

// File: stopwatch_core/time_counter.sv
`timescale 1ns/1ns

module time_counter
    import stopwatch_pkg::*;
(
    input  logic      clk,
    input  logic      rst_deb,
    input  logic      count_tick,
    input  logic      adj_tick,
    input  logic      pause_pulse,
    input  logic      adj,
    input  logic      sel,
    input  logic      load_pulse,
    input  bcd_time_t load_time,
    output bcd_time_t cur_time,
    output logic      paused
);

    bcd_time_t time_q;
    logic      do_count;
    logic      do_adj;

    // one second up, stops at 59:59
    function automatic bcd_time_t count_up(input bcd_time_t t);
        digit_t m10;
        digit_t m1;
        digit_t s10;
        digit_t s1;
        {m10, m1, s10, s1} = t;
        if (t != 16'h5959)
        begin
            if (s1 != 4'd9)
                s1 = s1 + 4'd1;
            else
            begin
                s1 = 4'd0;
                if (s10 != 4'd5)
                    s10 = s10 + 4'd1;
                else
                begin
                    s10 = 4'd0;
                    // carry into minutes
                    if (m1 != 4'd9)
                        m1 = m1 + 4'd1;
                    else
                    begin
                        m1  = 4'd0;
                        m10 = m10 + 4'd1;
                    end
                end
            end
        end
        return {m10, m1, s10, s1};
    endfunction

    // field plus two, 58 -> 00 and 59 -> 01
    function automatic logic [7:0] adj_step(input digit_t tens, input digit_t ones);
        digit_t t_n;
        digit_t o_n;
        if (ones == 4'd8 || ones == 4'd9)
        begin
            o_n = (ones == 4'd8) ? 4'd0 : 4'd1;
            t_n = (tens == 4'd5) ? 4'd0 : tens + 4'd1;
        end
        else
        begin
            o_n = ones + 4'd2;
            t_n = tens;
        end
        return {t_n, o_n};
    endfunction

    // ticks are ignored while paused
    assign do_count = count_tick && !adj && !paused;
    assign do_adj   = adj_tick && adj && !paused;

    always_ff @(posedge clk or posedge rst_deb)
    begin
        if (rst_deb)
        begin
            time_q <= '0;
            paused <= 1'b0;
        end
        else
        begin
            if (pause_pulse)
                paused <= ~paused;

            // load wins over a tick in the same cycle
            if (load_pulse)
                time_q <= load_time;
            else if (do_count)
                time_q <= count_up(time_q);
            else if (do_adj)
            begin
                if (sel)
                    time_q[7:0] <= adj_step(time_q[7:4], time_q[3:0]);
                else
                    time_q[15:8] <= adj_step(time_q[15:12], time_q[11:8]);
            end
        end
    end

    assign cur_time = time_q;

endmodule

// File: stopwatch_core/timebase.sv
`timescale 1ns/1ns
`include "stopwatch_config.svh"

module timebase
    import stopwatch_pkg::*;
(
    input  logic      clk,
    input  logic      rst_deb,
    input  logic      run,
    input  logic      adj,
    input  prescale_t prescale,
    output logic      count_tick,
    output logic      adj_tick,
    output logic      refresh_en,
    output logic      blink
);

    localparam int REF_W   = $clog2(`SW_REFRESH_DIV);
    localparam int BLINK_W = $clog2(`SW_BLINK_DIV);

    logic               run_q;
    logic               adj_q;
    logic               mode_chg;
    prescale_t          pre_cnt;
    prescale_t          period;
    logic [REF_W-1:0]   ref_cnt;
    logic [BLINK_W-1:0] blink_cnt;

    //////////////////////////////
    // tick prescaler
    //////////////////////////////

    // adjust steps twice as fast, prescale must be 4 or more
    assign period   = adj ? (prescale >> 1) : prescale;
    // restart on any mode change
    assign mode_chg = (run != run_q) || (adj != adj_q);

    always_ff @(posedge clk or posedge rst_deb)
    begin
        if (rst_deb)
        begin
            run_q      <= 1'b0;
            adj_q      <= 1'b0;
            pre_cnt    <= '0;
            count_tick <= 1'b0;
            adj_tick   <= 1'b0;
        end
        else
        begin
            run_q      <= run;
            adj_q      <= adj;
            count_tick <= 1'b0;
            adj_tick   <= 1'b0;
            if (!(run || adj))
                pre_cnt <= '0;
            // first cycle of the new mode already counts
            else if (mode_chg)
                pre_cnt <= prescale_t'(1);
            else if (pre_cnt == period - 1'b1)
            begin
                pre_cnt <= '0;
                if (adj)
                    adj_tick <= 1'b1;
                else
                    count_tick <= 1'b1;
            end
            else
                pre_cnt <= pre_cnt + 1'b1;
        end
    end

    //////////////////////////////
    // display enables
    //////////////////////////////

    always_ff @(posedge clk or posedge rst_deb)
    begin
        if (rst_deb)
        begin
            ref_cnt    <= '0;
            refresh_en <= 1'b0;
            blink_cnt  <= '0;
            blink      <= 1'b0;
        end
        else
        begin
            // free running, one pulse per divider period
            refresh_en <= (ref_cnt == REF_W'(`SW_REFRESH_DIV - 1));
            if (ref_cnt == REF_W'(`SW_REFRESH_DIV - 1))
                ref_cnt <= '0;
            else
                ref_cnt <= ref_cnt + 1'b1;

            // blink level flips every half period
            if (blink_cnt == BLINK_W'(`SW_BLINK_DIV - 1))
            begin
                blink_cnt <= '0;
                blink     <= ~blink;
            end
            else
                blink_cnt <= blink_cnt + 1'b1;
        end
    end

endmodule

// File: verification/clock_gen.sv
`timescale 1ns/1ns

module clock_gen #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst_deb
);

    // free running clock, 100 ns by default
    initial
    begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // reset released on a rising edge
    initial
    begin
        rst_deb = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_deb <= 1'b0;
    end

endmodule

// File: verification/stopwatch_asserts.sv
`timescale 1ns/1ns

module stopwatch_asserts
    import stopwatch_pkg::*;
(
    input logic   clk,
    input logic   rst_deb,
    input logic   psel,
    input logic   penable,
    input logic   pready,
    input logic   pslverr,
    input anode_t an
);

    // number of failed properties so far
    int fail_count = 0;

    // display dark or exactly one digit driven
    anode_onecold: assert property (@(posedge clk) disable iff (rst_deb)
        (an == 4'b1111) || $onehot(~an))
    else
    begin
        fail_count++;
        $error("anode select %b drives more than one digit", an);
    end

    // no wait states on the bus
    pready_high: assert property (@(posedge clk) disable iff (rst_deb) pready)
    else
    begin
        fail_count++;
        $error("pready went low");
    end

    // slave error only in the access phase
    pslverr_in_access: assert property (@(posedge clk) disable iff (rst_deb)
        pslverr |-> (psel && penable))
    else
    begin
        fail_count++;
        $error("pslverr high outside an access cycle");
    end

endmodule

// File: verification/stopwatch_tb.sv
`timescale 1ns/1ns
`include "stopwatch_config.svh"

module stopwatch_tb
    import stopwatch_pkg::*;
    import apb_pkg::*;
();

    localparam int NUM_COUNT    = 5;
    localparam int NUM_ADJ      = 9;
    localparam int NUM_RANDOM   = 16;
    localparam int ADJ_PRESCALE = 16;
    localparam apb_data_t RUN_CMD = apb_data_t'(1) << CTRL_RUN_BIT;
    localparam apb_data_t ADJ_CMD = apb_data_t'(1) << CTRL_ADJ_BIT;
    localparam apb_data_t SEC_CMD = apb_data_t'(1) << CTRL_SEL_BIT;

    // load time, prescale, ticks, expected time
    localparam logic [63:0] COUNT_TABLE [NUM_COUNT] = '{
        {16'h0000, 16'd8,  16'd3, 16'h0003},
        {16'h0058, 16'd10, 16'd4, 16'h0102},
        {16'h0959, 16'd8,  16'd2, 16'h1001},
        {16'h5958, 16'd8,  16'd5, 16'h5959},
        {16'h1234, 16'd12, 16'd6, 16'h1240}
    };

    // start time, sel (1 is seconds), expected time after one step
    localparam logic [39:0] ADJ_TABLE [NUM_ADJ] = '{
        {16'h0800, 8'd0, 16'h1000},
        {16'h0900, 8'd0, 16'h1100},
        {16'h5800, 8'd0, 16'h0000},
        {16'h5930, 8'd0, 16'h0130},
        {16'h1208, 8'd1, 16'h1210},
        {16'h1209, 8'd1, 16'h1211},
        {16'h3358, 8'd1, 16'h3300},
        {16'h4459, 8'd1, 16'h4401},
        {16'h0203, 8'd1, 16'h0205}
    };

    // active low digit patterns 0 to 9
    localparam seg_t SEG_PATTERN [10] = '{
        8'hC0, 8'hF9, 8'hA4, 8'hB0, 8'h99, 8'h92, 8'h82, 8'hF8, 8'h80, 8'h90
    };

    logic        clk;
    logic        rst_deb;
    logic        pause_btn;
    logic        psel;
    logic        penable;
    logic        pwrite;
    apb_addr_t   paddr;
    apb_data_t   pwdata;
    apb_data_t   prdata;
    logic        pready;
    logic        pslverr;
    seg_t        seg;
    anode_t      an;

    int          errors      = 0;
    int          checks      = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    // rising edges seen by the design since reset release
    int          live_edges  = 0;
    logic [31:0] rng         = 32'h6475_de88;

    clock_gen u_clock_gen (
        .clk     (clk),
        .rst_deb (rst_deb)
    );

    stopwatch_top dut (
        .clk       (clk),
        .rst_deb   (rst_deb),
        .pause_btn (pause_btn),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .seg       (seg),
        .an        (an)
    );

    bind stopwatch_top stopwatch_asserts u_stopwatch_asserts (
        .clk     (clk),
        .rst_deb (rst_deb),
        .psel    (psel),
        .penable (penable),
        .pready  (pready),
        .pslverr (pslverr),
        .an      (an)
    );

    //////////////////////////////
    // helpers
    //////////////////////////////

    function automatic logic [31:0] next_random();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // tens below 6, ones below 10
    function automatic logic bcd_ok(input bcd_time_t t);
        return t[15:12] < 4'd6 && t[11:8] < 4'd10 && t[7:4] < 4'd6 && t[3:0] < 4'd10;
    endfunction

    // cycle budget of every section, plus margin
    function automatic int test_budget();
        int total;
        total = 40 + 4 * (`SW_DEB_LEN + 12) + 80;
        for (int i = 0; i < NUM_COUNT; i++)
            total += int'(COUNT_TABLE[i][47:32]) * int'(COUNT_TABLE[i][31:16]) + 40;
        total += NUM_ADJ * (ADJ_PRESCALE / 2 + 40);
        total += NUM_RANDOM * 12 + 40;
        total += 20 * `SW_REFRESH_DIV + 150;
        return total + 500;
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    // setup cycle, access cycle, write lands on the closing edge
    task automatic write_reg(input apb_addr_t addr, input apb_data_t data, output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        err = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic read_reg(input apb_addr_t addr, output apb_data_t data, output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        // prdata valid mid access cycle
        @(negedge clk);
        data = prdata;
        err  = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic check_read(input apb_addr_t addr, input apb_data_t exp, input string what);
        apb_data_t data;
        logic      err;
        read_reg(addr, data, err);
        checks++;
        if (err !== 1'b0 || data !== exp)
        begin
            errors++;
            $display("error @ %0t ns: %s read %h (pslverr %b), expected %h",
                     $time, what, data, err, exp);
        end
    endtask

    task automatic press_button(input int cycles);
        @(posedge clk);
        pause_btn <= 1'b1;
        repeat (cycles) @(posedge clk);
        pause_btn <= 1'b0;
        wait_cycles(3);
    endtask

    // sample seg and an on each falling edge
    task automatic scan_window(input int cycles, input bcd_time_t shown,
                               input logic in_adj, input logic sel_sec);
        logic [3:0] seen;
        int         pos;
        logic       blink_lvl;
        logic       blank;
        seg_t       exp_seg;
        seen = '0;
        // seg lags its inputs by one edge
        @(posedge clk);
        repeat (cycles)
        begin
            @(negedge clk);
            case (an)
                4'b0111: pos = 3;
                4'b1011: pos = 2;
                4'b1101: pos = 1;
                4'b1110: pos = 0;
                default: pos = -1;
            endcase
            checks++;
            if (pos < 0)
            begin
                errors++;
                $display("error @ %0t ns: anode select %b is not one digit", $time, an);
            end
            else
            begin
                seen[pos] = 1'b1;
                // blink level before the edge that loaded seg
                blink_lvl = (((live_edges - 1) / `SW_BLINK_DIV) % 2) == 1;
                blank     = in_adj && !blink_lvl && ((pos < 2) == sel_sec);
                exp_seg   = blank ? 8'hFF : SEG_PATTERN[shown[pos*4 +: 4]];
                if (seg !== exp_seg)
                begin
                    errors++;
                    $display("error @ %0t ns: digit %0d shows seg %h, expected %h",
                             $time, pos, seg, exp_seg);
                end
            end
        end
        checks++;
        if (seen !== 4'hF)
        begin
            errors++;
            $display("error @ %0t ns: only digits %b were scanned", $time, seen);
        end
    endtask

    //////////////////////////////
    // test sections
    //////////////////////////////

    task automatic count_rows();
        logic [63:0] row;
        logic        err;
        for (int i = 0; i < NUM_COUNT; i++)
        begin
            row = COUNT_TABLE[i];
            write_reg(REG_TIME, apb_data_t'(row[63:48]), err);
            write_reg(REG_PRESCALE, apb_data_t'(row[47:32]), err);
            write_reg(REG_CTRL, RUN_CMD, err);
            wait_cycles(int'(row[47:32]) * int'(row[31:16]) + 1);
            write_reg(REG_CTRL, '0, err);
            check_read(REG_TIME, apb_data_t'(row[15:0]), $sformatf("count row %0d", i));
        end
    endtask

    task automatic pause_button_checks();
        logic err;
        // too short to qualify
        press_button(`SW_DEB_LEN - 4);
        check_read(REG_STATUS, 32'h0, "status after short press");
        press_button(`SW_DEB_LEN + 4);
        check_read(REG_STATUS, 32'h1, "status after long press");
        // ticks ignored while paused
        write_reg(REG_TIME, 32'h0420, err);
        write_reg(REG_PRESCALE, 32'd8, err);
        write_reg(REG_CTRL, RUN_CMD, err);
        wait_cycles(4 * 8 + 1);
        write_reg(REG_CTRL, '0, err);
        check_read(REG_TIME, 32'h0420, "time while paused");
        press_button(`SW_DEB_LEN + 4);
        check_read(REG_STATUS, 32'h0, "status after second press");
    endtask

    task automatic adjust_rows();
        logic [39:0] row;
        logic        err;
        write_reg(REG_PRESCALE, ADJ_PRESCALE, err);
        for (int i = 0; i < NUM_ADJ; i++)
        begin
            row = ADJ_TABLE[i];
            write_reg(REG_TIME, apb_data_t'(row[39:24]), err);
            write_reg(REG_CTRL, ADJ_CMD | (row[16] ? SEC_CMD : '0), err);
            wait_cycles(ADJ_PRESCALE / 2 + 1);
            write_reg(REG_CTRL, '0, err);
            check_read(REG_TIME, apb_data_t'(row[15:0]), $sformatf("adjust row %0d", i));
        end
    endtask

    task automatic register_error_checks();
        apb_data_t   data;
        logic        err;
        logic [31:0] r;
        bcd_time_t   cand;
        bcd_time_t   model;
        read_reg(8'h10, data, err);
        checks++;
        if (err !== 1'b1 || data !== '0)
        begin
            errors++;
            $display("error @ %0t ns: unmapped read gave %h with pslverr %b", $time, data, err);
        end
        write_reg(REG_STATUS, 32'h1, err);
        checks++;
        if (err !== 1'b1)
        begin
            errors++;
            $display("error @ %0t ns: write to REG_STATUS without pslverr", $time);
        end
        check_read(REG_STATUS, 32'h0, "status after rejected write");
        model = 16'h0000;
        write_reg(REG_TIME, 32'h0, err);
        for (int i = 0; i < NUM_RANDOM; i++)
        begin
            r    = next_random();
            // digits up to 6 and 10 give a mix of good and bad codes
            cand = {4'(r[3:0] % 7), 4'(r[7:4] % 11), 4'(r[11:8] % 7), 4'(r[15:12] % 11)};
            write_reg(REG_TIME, apb_data_t'(cand), err);
            checks++;
            if (err !== !bcd_ok(cand))
            begin
                errors++;
                $display("error @ %0t ns: REG_TIME write %h gave pslverr %b", $time, cand, err);
            end
            if (bcd_ok(cand))
                model = cand;
            check_read(REG_TIME, apb_data_t'(model), "REG_TIME after random write");
        end
    endtask

    task automatic display_checks();
        logic        err;
        logic [31:0] r;
        bcd_time_t   shown;
        r     = next_random();
        shown = {4'(r[3:0] % 6), 4'(r[7:4] % 10), 4'(r[11:8] % 6), 4'(r[15:12] % 10)};
        write_reg(REG_TIME, apb_data_t'(shown), err);
        scan_window(4 * `SW_REFRESH_DIV, shown, 1'b0, 1'b0);
        // long adjust period keeps the time still
        write_reg(REG_PRESCALE, 32'd100000, err);
        write_reg(REG_CTRL, ADJ_CMD | SEC_CMD, err);
        scan_window(8 * `SW_REFRESH_DIV, shown, 1'b1, 1'b1);
        write_reg(REG_CTRL, ADJ_CMD, err);
        scan_window(8 * `SW_REFRESH_DIV, shown, 1'b1, 1'b0);
        write_reg(REG_CTRL, '0, err);
        check_read(REG_TIME, apb_data_t'(shown), "time after display checks");
    endtask

    //////////////////////////////
    // sequence and watchdog
    //////////////////////////////

    always @(posedge clk)
    begin
        if (!rst_deb)
            live_edges <= live_edges + 1;
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit)
        begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial
    begin
        int assert_fails;
        cycle_limit = test_budget();
        pause_btn   = 1'b0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        wait (rst_deb === 1'b0);
        @(negedge clk);

        // dark display right after reset
        checks++;
        if (an !== 4'hF || seg !== 8'hFF)
        begin
            errors++;
            $display("error @ %0t ns: after reset an %b seg %h, expected all ones",
                     $time, an, seg);
        end
        check_read(REG_TIME, 32'h0, "REG_TIME after reset");
        check_read(REG_PRESCALE, `SW_PRESCALE_RESET, "REG_PRESCALE after reset");
        check_read(REG_STATUS, 32'h0, "REG_STATUS after reset");

        count_rows();
        pause_button_checks();
        adjust_rows();
        register_error_checks();
        display_checks();

        assert_fails = dut.u_stopwatch_asserts.fail_count;
        $display("done: %0d checks, %0d check errors, %0d assertion failures",
                 checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+common
common/stopwatch_pkg.sv
common/apb_pkg.sv
hw/button_debouncer.sv
hw/apb_regs.sv
stopwatch_core/timebase.sv
stopwatch_core/time_counter.sv
hw/display_scan.sv
hw/stopwatch_top.sv
verification/clock_gen.sv
verification/stopwatch_asserts.sv
verification/stopwatch_tb.sv
